// File: include/boa_defines.svh
/*
 * RV32I constants for the front end.
 * Trap cause codes and the opcodes that pre-decode recognizes.
 */
`ifndef BOA_DEFINES_SVH
`define BOA_DEFINES_SVH

// Instruction address misaligned.
`define RV_ECAUSE_IALIGN 4'd0

// Jump and link, unconditional.
`define RV_OP_JAL        7'b1101111
// Conditional branches, all funct3 variants.
`define RV_OP_BRANCH     7'b1100011

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps \
    --top-module boa_frontend_tb -f tb.f -Mdir obj_dir -o boa_frontend_sim

# Assertion errors are counted by the testbench, so let the run continue.
./obj_dir/boa_frontend_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "Simulation run: PASS"
else
    echo "Simulation run: FAIL"
    exit 1
fi

// File: src/boa_frontend.sv
/*
 * RV32I front end top level.
 * Program memory, fetch and pre-decode wired into one fetch path.
 */
`timescale 1ns/1ps
`default_nettype none

module boa_frontend #(
    parameter logic [31:0] entrypoint  = 32'h0000_0000,
    parameter int          wait_states = 1,
    parameter int          mem_depth   = boa_pkg::mem_words
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         correct,
    input  boa_pkg::pc_t                 correct_target,
    input  logic                         load_en,
    input  logic [$clog2(mem_depth)-1:0] load_addr,
    input  logic [31:0]                  load_data,
    output boa_pkg::fetch_t              out
);
    import boa_pkg::*;

    // Fetch to memory.
    mem_req_t  mem_req;
    mem_resp_t mem_resp;
    // Fetch to pre-decode.
    fetch_t    fetch;
    // Pre-decode back to fetch.
    logic      predict;
    pc_t       predict_target;
    logic      clear;

    boa_prog_mem #(
        .wait_states (wait_states),
        .mem_depth   (mem_depth)
    ) i_prog_mem (
        .clk       (clk),
        .rst       (rst),
        .req       (mem_req),
        .resp      (mem_resp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    boa_stage_if #(
        .entrypoint (entrypoint)
    ) i_stage_if (
        .clk            (clk),
        .rst            (rst),
        .clear          (clear),
        .mem_req        (mem_req),
        .mem_resp       (mem_resp),
        .result         (fetch),
        .predict        (predict),
        .predict_target (predict_target),
        .correct        (correct),
        .correct_target (correct_target),
        .stall          (stall)
    );

    boa_stage_pd i_stage_pd (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .correct        (correct),
        .in             (fetch),
        .out            (out),
        .predict        (predict),
        .predict_target (predict_target),
        .clear          (clear)
    );

endmodule

`default_nettype wire

// File: src/boa_pkg.sv
/*
 * Front end shared types.
 * Memory request and response, the fetch result and the PC format.
 */
`default_nettype none

package boa_pkg;

    // Instruction PC in halfword units.
    // Bit 0 of a byte address is always zero and is not stored.
    typedef logic [31:1] pc_t;

    // Program memory read request.
    typedef struct packed {
        // Read enable.
        logic        re;
        // Word address.
        logic [31:2] addr;
    } mem_req_t;

    // Program memory read response.
    typedef struct packed {
        // Data word matches the last accepted address.
        logic        ready;
        // Read data.
        logic [31:0] rdata;
    } mem_resp_t;

    // One fetched instruction, or an alignment trap in its place.
    typedef struct packed {
        // Instruction word is usable.
        logic        valid;
        // PC of this entry.
        pc_t         pc;
        // Raw instruction word.
        logic [31:0] insn;
        // Trap instead of an instruction.
        logic        trap;
        // Trap cause code.
        logic [3:0]  cause;
    } fetch_t;

    // Default program memory depth in words.
    localparam int mem_words = 256;

endpackage

`default_nettype wire

// File: src/boa_prog_mem.sv
/*
 * Program memory with wait states.
 * Word array with a registered read address, a wait counter that
 * gates ready, and a write port for loading the program.
 */
`timescale 1ns/1ps
`default_nettype none

module boa_prog_mem #(
    parameter int wait_states = 1,
    parameter int mem_depth   = boa_pkg::mem_words
) (
    input  logic                         clk,
    input  logic                         rst,
    input  boa_pkg::mem_req_t            req,
    output boa_pkg::mem_resp_t           resp,
    input  logic                         load_en,
    input  logic [$clog2(mem_depth)-1:0] load_addr,
    input  logic [31:0]                  load_data
);
    // Index width into the array.
    localparam int aw = $clog2(mem_depth);
    // Counter width, one bit minimum.
    localparam int cw = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

    logic [31:0]   mem [mem_depth];

    // Read in flight.
    logic          re_q;
    // Address of the read in flight.
    logic [31:2]   addr_q;
    // Remaining wait cycles.
    logic [cw-1:0] cnt;
    logic          ready;
    logic          accept;

    assign ready = re_q && (cnt == '0);

    // Start a new read when idle, when the address changes, or right
    // after a word is delivered.
    // Same address during a wait keeps counting.
    assign accept = req.re && (!re_q || (req.addr != addr_q) || ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            re_q <= 1'b0;
        end else if (accept) begin
            re_q <= 1'b1;
        end else if (ready) begin
            // Delivered once. Unclaimed words are fetched again.
            re_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req.addr;
            cnt    <= cw'(wait_states);
        end else if (re_q && (cnt != '0)) begin
            cnt    <= cnt - cw'(1);
        end
    end

    // Load port.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // Read from the latched address.
    // Upper address bits wrap into the array.
    assign resp.ready = ready;
    assign resp.rdata = mem[addr_q[aw+1:2]];

endmodule

`default_nettype wire

// File: src/boa_stage_if.sv
/*
 * Instruction fetch stage.
 * Holds the PC, picks the next fetch word by redirect priority and
 * turns memory responses into fetch results or alignment traps.
 */
`timescale 1ns/1ps
`default_nettype none
`include "boa_defines.svh"

module boa_stage_if #(
    parameter logic [31:0] entrypoint = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    output boa_pkg::mem_req_t  mem_req,
    input  boa_pkg::mem_resp_t mem_resp,
    output boa_pkg::fetch_t    result,
    input  logic               predict,
    input  boa_pkg::pc_t       predict_target,
    input  logic               correct,
    input  boa_pkg::pc_t       correct_target,
    input  logic               stall
);
    import boa_pkg::*;

    // Current fetch PC.
    pc_t         pc;
    // PC for the next cycle.
    pc_t         pc_next;
    // Word after the current one.
    logic [31:2] seq_addr;
    // Result of this cycle is thrown away.
    logic        squash;
    // PC register moves this cycle.
    logic        advance;

    assign seq_addr = pc[31:2] + 30'd1;
    assign squash   = predict || correct || clear;

    // A correction must land even under stall.
    // Otherwise it would be lost, so it forces the PC and the request.
    assign advance  = !stall || correct;

    // Redirect priority.
    always_comb begin
        mem_req.re = advance;
        if (correct) begin
            mem_req.addr = correct_target[31:2];
            pc_next      = correct_target;
        end else if (predict) begin
            mem_req.addr = predict_target[31:2];
            pc_next      = predict_target;
        end else if (mem_resp.ready) begin
            // Word done, go sequential.
            // A misaligned PC also lands on the next aligned word here.
            mem_req.addr = seq_addr;
            pc_next      = {seq_addr, 1'b0};
        end else begin
            // Still waiting. Keep asking for the same word.
            mem_req.addr = pc[31:2];
            pc_next      = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= entrypoint[31:1];
        end else if (advance) begin
            pc <= pc_next;
        end
    end

    // Result straight from the memory response.
    // PC bit 1 set means a misaligned target, reported as a trap.
    always_comb begin
        result.valid = mem_resp.ready && !squash && !pc[1];
        result.trap  = mem_resp.ready && !squash && pc[1];
        result.pc    = pc;
        result.insn  = mem_resp.rdata;
        result.cause = `RV_ECAUSE_IALIGN;
    end

endmodule

`default_nettype wire

// File: src/boa_stage_pd.sv
/*
 * Pre-decode stage.
 * Registers fetch results, predicts JAL and backward branches,
 * and holds its output under stall.
 */
`timescale 1ns/1ps
`default_nettype none
`include "boa_defines.svh"

module boa_stage_pd (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            correct,
    input  boa_pkg::fetch_t in,
    output boa_pkg::fetch_t out,
    output logic            predict,
    output boa_pkg::pc_t    predict_target,
    output logic            clear
);
    import boa_pkg::*;

    // Control part of the held entry.
    logic        held_valid;
    logic        held_trap;
    // Payload part of the held entry.
    pc_t         held_pc;
    logic [31:0] held_insn;
    logic [3:0]  held_cause;

    logic [6:0]  opcode;
    // Immediates in halfword units, sign-extended to PC width.
    pc_t         j_off;
    pc_t         b_off;
    logic        is_jal;
    logic        is_back_branch;
    logic        hit;

    // Correction empties the register, stall or not.
    always_ff @(posedge clk) begin
        if (rst || correct) begin
            held_valid <= 1'b0;
            held_trap  <= 1'b0;
        end else if (!stall) begin
            held_valid <= in.valid;
            held_trap  <= in.trap;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            held_pc    <= in.pc;
            held_insn  <= in.insn;
            held_cause <= in.cause;
        end
    end

    assign opcode = held_insn[6:0];

    // J-immediate, bit 0 dropped.
    assign j_off = {{11{held_insn[31]}}, held_insn[31], held_insn[19:12],
                    held_insn[20], held_insn[30:21]};

    // B-immediate, bit 0 dropped.
    assign b_off = {{19{held_insn[31]}}, held_insn[31], held_insn[7],
                    held_insn[30:25], held_insn[11:8]};

    assign is_jal = (opcode == `RV_OP_JAL);

    // Negative offset only.
    // funct3 010 and 011 are not branches.
    assign is_back_branch = (opcode == `RV_OP_BRANCH)
                          && (held_insn[14:13] != 2'b01)
                          && held_insn[31];

    // Traps carry no usable word.
    assign hit = held_valid && (is_jal || is_back_branch);

    // Fires only in the cycle the entry is consumed, so once per entry.
    assign predict        = hit && !stall;
    assign predict_target = held_pc + (is_jal ? j_off : b_off);

    // Squash the fetch in flight on any redirect.
    assign clear = predict || correct;

    assign out = '{valid: held_valid, pc: held_pc, insn: held_insn,
                   trap: held_trap, cause: held_cause};

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
src/boa_pkg.sv
src/boa_prog_mem.sv
src/boa_stage_if.sv
src/boa_stage_pd.sv
src/boa_frontend.sv
tb/boa_clkgen.sv
tb/boa_frontend_sva.sv
tb/boa_frontend_tb.sv

// File: tb/boa_clkgen.sv
/*
 * Testbench clock and reset.
 * Free running clock, reset held high for a set number of cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module boa_clkgen #(
    parameter int half_period  = 50,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Reset drops right after a rising edge, like the other inputs.
    initial begin
        rst <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/boa_frontend_sva.sv
/*
 * Output protocol assertions for the front end.
 * Held items under stall, one-cycle prediction strobe,
 * and a quiet output after reset.
 */
`timescale 1ns/1ps
`default_nettype none

module boa_frontend_sva (
    input logic            clk,
    input logic            rst,
    input logic            stall,
    input logic            correct,
    input logic            predict,
    input boa_pkg::fetch_t out
);
    // Failed assertions so far.
    int fail_count = 0;

    // Held item stays put under stall.
    // Only a correction may flush it.
    hold_under_stall: assert property (
        @(posedge clk) disable iff (rst)
        (stall && !correct && (out.valid || out.trap)) |=> $stable(out)
    ) else begin
        fail_count++;
        $error("output item changed while stall was high");
    end

    // Prediction fires once per entry.
    predict_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        predict |=> !predict
    ) else begin
        fail_count++;
        $error("prediction strobe held for more than one cycle");
    end

    reset_clears_output: assert property (
        @(posedge clk)
        rst |=> (!out.valid && !out.trap)
    ) else begin
        fail_count++;
        $error("output item present right after reset");
    end

endmodule

bind boa_frontend boa_frontend_sva i_frontend_sva (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .correct (correct),
    .predict (predict),
    .out     (out)
);

`default_nettype wire

// File: tb/boa_frontend_tb.sv
/*
 * Front end testbench.
 * Loads a random RV32I program, runs fetch under random stalls and
 * corrections, and checks each consumed item against a PC model.
 */
`timescale 1ns/1ps
`default_nettype none

module boa_frontend_tb;
    import boa_pkg::*;

    localparam logic [31:0] entrypoint   = 32'h0000_0040;
    localparam int          wait_states  = 2;
    localparam int          mem_depth    = 64;
    localparam int          aw           = $clog2(mem_depth);
    localparam int          reset_cycles = 8;
    // Program base, byte address.
    localparam logic [31:0] prog_base    = 32'h0000_0000;
    localparam int          n_items      = 500;
    localparam int          load_cycles  = reset_cycles + mem_depth + 16;
    localparam int          cycle_limit  = n_items * (wait_states + 2) * 4 + load_cycles;

    logic          clk;
    logic          rst;
    logic          stall;
    logic          correct;
    pc_t           correct_target;
    logic          load_en;
    logic [aw-1:0] load_addr;
    logic [31:0]   load_data;
    fetch_t        out;

    // Program image as loaded.
    logic [31:0]   prog [mem_depth];
    // Model state, byte address of the next expected item.
    logic [31:0]   exp_pc;
    string         exp_reason;
    logic          running;
    int            consumed = 0;
    int            cycles   = 0;
    int            errors   = 0;

    boa_clkgen #(
        .half_period  (50),
        .reset_cycles (reset_cycles)
    ) i_clkgen (
        .clk (clk),
        .rst (rst)
    );

    boa_frontend #(
        .entrypoint  (entrypoint),
        .wait_states (wait_states),
        .mem_depth   (mem_depth)
    ) i_boa_frontend (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .correct        (correct),
        .correct_target (correct_target),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .out            (out)
    );

    // J-type immediate in bytes, per the ISA layout.
    function automatic logic [31:0] jal_offset(input logic [31:0] insn);
        return {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] branch_offset(input logic [31:0] insn);
        return {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    endfunction

    // Conditional branch, funct3 010 and 011 are reserved.
    function automatic logic is_branch(input logic [31:0] insn);
        return (insn[6:0] == 7'b1100011) && (insn[14:12] != 3'b010)
            && (insn[14:12] != 3'b011);
    endfunction

    function automatic logic [31:0] encode_branch(input logic [31:0] off,
            input logic [2:0] funct3, input logic [4:0] rs1, input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_jal(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // One of BEQ, BNE, BLT, BGE, BLTU, BGEU.
    function automatic logic [2:0] pick_funct3();
        logic [2:0] f;
        f = 3'($urandom % 6);
        if (f >= 3'd2) f = f + 3'd2;
        return f;
    endfunction

    // Memory wraps on its depth.
    function automatic int word_index(input logic [31:0] byte_addr);
        return int'((byte_addr >> 2) % mem_depth);
    endfunction

    // Any program word, now and then an odd halfword.
    function automatic pc_t random_target();
        logic [31:0] byte_addr;
        byte_addr = prog_base + (($urandom % mem_depth) * 4);
        if ($urandom % 4 == 0) byte_addr = byte_addr + 32'd2;
        return byte_addr[31:1];
    endfunction

    task automatic build_program();
        int          kind;
        int          target;
        logic [31:0] off;
        logic [31:0] word;
        for (int i = 0; i < mem_depth; i++) begin
            kind = int'($urandom % 10);
            // Plain OP-IMM word unless replaced below.
            word      = $urandom;
            word[6:0] = 7'b0010011;
            if (kind >= 5 && kind <= 6 && i < mem_depth - 1) begin
                target = i + 1 + int'($urandom % (mem_depth - 1 - i));
                off    = (target - i) * 4;
                word   = encode_branch(off, pick_funct3(), 5'($urandom), 5'($urandom));
            end else if (kind == 7 && i > 0) begin
                // Backward, stays inside the program.
                target = int'($urandom % i);
                off    = (target - i) * 4;
                word   = encode_branch(off, pick_funct3(), 5'($urandom), 5'($urandom));
            end else if (kind >= 8) begin
                target = int'($urandom % mem_depth) * 4;
                if ($urandom % 3 == 0) target = target + 2;
                off    = target - i * 4;
                word   = encode_jal(off, 5'($urandom));
            end
            prog[i] = word;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < mem_depth; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= aw'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (expected == actual) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Check one consumed item, then step the model.
    task automatic check_item();
        logic [31:0] pc_byte;
        logic [31:0] insn;
        logic        exp_trap;
        pc_byte  = {out.pc, 1'b0};
        // Expected word and trap come from the model PC.
        insn     = prog[word_index(exp_pc)];
        exp_trap = exp_pc[1];
        check_value(exp_reason, exp_pc, pc_byte);
        check_value("trap flag", {31'd0, exp_trap}, {31'd0, out.trap});
        check_value("valid flag", {31'd0, !exp_trap}, {31'd0, out.valid});
        if (exp_trap) begin
            check_value("trap cause", 32'd0, {28'd0, out.cause});
            exp_pc     = {exp_pc[31:2], 2'b00} + 32'd4;
            exp_reason = "trap resume";
        end else begin
            check_value("loaded word", insn, out.insn);
            if (insn[6:0] == 7'b1101111) begin
                exp_pc     = exp_pc + jal_offset(insn);
                exp_reason = "jal prediction";
            end else if (is_branch(insn) && insn[31]) begin
                exp_pc     = exp_pc + branch_offset(insn);
                exp_reason = "branch prediction";
            end else begin
                exp_pc     = exp_pc + 32'd4;
                exp_reason = "sequential";
            end
        end
        consumed++;
    endtask

    // Sample mid-cycle, when inputs and outputs are settled.
    always @(negedge clk) begin
        if (rst) begin
            assert (!out.valid && !out.trap) else begin
                errors++;
                $display("Output item present while reset is active");
            end
        end else if (running) begin
            if (!stall && (out.valid || out.trap)) check_item();
            // Correction overrides whatever was consumed.
            if (correct) begin
                exp_pc     = {correct_target, 1'b0};
                exp_reason = "correction";
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d items consumed",
                     cycles, consumed, n_items);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(37));
        // Fetch parked at the base through reset and load.
        stall          <= 1'b0;
        correct        <= 1'b1;
        correct_target <= prog_base[31:1];
        load_en        <= 1'b0;
        load_addr      <= '0;
        load_data      <= '0;
        running        = 1'b0;
        exp_pc         = prog_base;
        exp_reason     = "reset release";
        build_program();
        @(negedge rst);
        load_program();
        @(posedge clk);
        correct <= 1'b0;
        running = 1'b1;
        while (consumed < n_items) begin
            @(posedge clk);
            stall <= ($urandom % 4) == 0;
            if ($urandom % 24 == 0) begin
                correct        <= 1'b1;
                correct_target <= random_target();
            end else begin
                correct <= 1'b0;
            end
        end
        $display("Run done: %0d items, %0d check errors, %0d assertion errors",
                 consumed, errors, i_boa_frontend.i_frontend_sva.fail_count);
        if (errors == 0 && i_boa_frontend.i_frontend_sva.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
